//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module exec_core_tb \
		-f exec_core.f -o exec_core_tb
	./obj_dir/exec_core_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- exec_core.f
hdl/exec_pkg.sv
hdl/gpr_file.sv
hdl/issue_ctrl.sv
hdl/alu_unit.sv
hdl/muldiv_unit.sv
hdl/wb_arbiter.sv
hdl/exec_core.sv
tests/exec_core_tb.sv

//--- hdl/alu_unit.sv
// single-cycle integer alu, rv32i semantics, registered result
`timescale 1ns/1ns
`default_nettype none

module alu_unit #(
    parameter int DATA_W = 32
) (
    input  wire                             clk,
    input  wire                             rst_n_i,
    input  wire                             req_i,
    input  wire exec_pkg::op_e              op_i,
    input  wire [DATA_W-1:0]                opa_i,
    input  wire [DATA_W-1:0]                opb_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire exec_pkg::commit_id_t       id_i,
    output logic                            res_valid_o,
    output logic [exec_pkg::REG_ADDR_W-1:0] res_rd_o,
    output logic [DATA_W-1:0]               res_data_o,
    output exec_pkg::commit_id_t            res_id_o
);
    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(DATA_W);

    logic [SHAMT_W-1:0] shamt;
    logic [DATA_W-1:0]  result;

    assign shamt = opb_i[SHAMT_W-1:0];

    always_comb begin
        case (op_i)
            OP_ADD:  result = opa_i + opb_i;
            OP_SUB:  result = opa_i - opb_i;
            OP_AND:  result = opa_i & opb_i;
            OP_OR:   result = opa_i | opb_i;
            OP_XOR:  result = opa_i ^ opb_i;
            OP_SLL:  result = opa_i << shamt;
            OP_SRL:  result = opa_i >> shamt;
            OP_SRA:  result = $unsigned($signed(opa_i) >>> shamt);
            OP_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
            OP_SLTU: result = {{(DATA_W-1){1'b0}}, opa_i < opb_i};
            default: result = '0;   // mul/div ops never routed here
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= req_i;   // one cycle only, arbiter always takes it
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            res_data_o <= result;
            res_rd_o   <= rd_i;
            res_id_o   <= id_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_core.sv
// execution back end top, issue control, register file, alu, mul/div, write-back
`timescale 1ns/1ns
`default_nettype none

module exec_core #(
    parameter int DATA_W = 32
) (
    input  wire                             clk,
    input  wire                             rst_n_i,
    input  wire                             issue_valid_i,
    output wire                             issue_ready_o,
    input  wire exec_pkg::op_e              issue_op_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0]  issue_rd_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0]  issue_rs1_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0]  issue_rs2_i,
    input  wire                             issue_use_imm_i,
    input  wire [DATA_W-1:0]                issue_imm_i,
    output wire                             commit_valid_o,
    output exec_pkg::commit_id_t            commit_id_o,
    output wire [exec_pkg::REG_ADDR_W-1:0]  commit_rd_o,
    output wire [DATA_W-1:0]                commit_data_o
);
    import exec_pkg::*;

    // register file ports
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, reg_waddr;
    logic [DATA_W-1:0]     rs1_data, rs2_data, reg_wdata;
    logic                  reg_we;
    // dispatch
    logic                  alu_req, md_req, md_busy;
    op_e                   disp_op;
    logic [DATA_W-1:0]     disp_opa, disp_opb;
    logic [REG_ADDR_W-1:0] disp_rd;
    commit_id_t            disp_id;
    // unit results
    logic                  alu_res_valid, md_res_valid, md_wb_ready;
    logic [REG_ADDR_W-1:0] alu_res_rd, md_res_rd;
    logic [DATA_W-1:0]     alu_res_data, md_res_data;
    commit_id_t            alu_res_id, md_res_id;

    gpr_file #(.DATA_W(DATA_W)) u_gpr_file (
        .clk(clk), .rst_n_i(rst_n_i),
        .we_i(reg_we), .waddr_i(reg_waddr), .wdata_i(reg_wdata),
        .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    issue_ctrl #(.DATA_W(DATA_W)) u_issue_ctrl (
        .clk(clk), .rst_n_i(rst_n_i),
        .issue_valid_i(issue_valid_i), .issue_ready_o(issue_ready_o),
        .issue_op_i(issue_op_i), .issue_rd_i(issue_rd_i),
        .issue_rs1_i(issue_rs1_i), .issue_rs2_i(issue_rs2_i),
        .issue_use_imm_i(issue_use_imm_i), .issue_imm_i(issue_imm_i),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .md_busy_i(md_busy),
        .clear_valid_i(commit_valid_o), .clear_rd_i(commit_rd_o),   // commit frees rd
        .alu_req_o(alu_req), .md_req_o(md_req), .op_o(disp_op),
        .opa_o(disp_opa), .opb_o(disp_opb), .rd_o(disp_rd), .id_o(disp_id)
    );

    alu_unit #(.DATA_W(DATA_W)) u_alu_unit (
        .clk(clk), .rst_n_i(rst_n_i),
        .req_i(alu_req), .op_i(disp_op), .opa_i(disp_opa), .opb_i(disp_opb),
        .rd_i(disp_rd), .id_i(disp_id),
        .res_valid_o(alu_res_valid), .res_rd_o(alu_res_rd),
        .res_data_o(alu_res_data), .res_id_o(alu_res_id)
    );

    muldiv_unit #(.DATA_W(DATA_W)) u_muldiv_unit (
        .clk(clk), .rst_n_i(rst_n_i),
        .req_i(md_req), .op_i(disp_op), .opa_i(disp_opa), .opb_i(disp_opb),
        .rd_i(disp_rd), .id_i(disp_id), .busy_o(md_busy),
        .res_valid_o(md_res_valid), .res_rd_o(md_res_rd),
        .res_data_o(md_res_data), .res_id_o(md_res_id),
        .wb_ready_i(md_wb_ready)
    );

    wb_arbiter #(.DATA_W(DATA_W)) u_wb_arbiter (
        .clk(clk), .rst_n_i(rst_n_i),
        .alu_valid_i(alu_res_valid), .alu_rd_i(alu_res_rd),
        .alu_data_i(alu_res_data), .alu_id_i(alu_res_id),
        .md_valid_i(md_res_valid), .md_rd_i(md_res_rd),
        .md_data_i(md_res_data), .md_id_i(md_res_id),
        .md_wb_ready_o(md_wb_ready),
        .reg_we_o(reg_we), .reg_waddr_o(reg_waddr), .reg_wdata_o(reg_wdata),
        .commit_valid_o(commit_valid_o), .commit_id_o(commit_id_o),
        .commit_rd_o(commit_rd_o), .commit_data_o(commit_data_o)
    );

endmodule

`default_nettype wire

//--- hdl/exec_pkg.sv
// shared widths, opcode and multiply/divide state enums, commit id type
`default_nettype none

package exec_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // rolling tag, wide enough for three instructions in flight
    typedef logic [1:0] commit_id_t;

    typedef enum logic [3:0] {
        // single-cycle alu group
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_SRA   = 4'd7,
        OP_SLT   = 4'd8,
        OP_SLTU  = 4'd9,
        // iterative unsigned mul/div group
        OP_MUL   = 4'd10,
        OP_MULHU = 4'd11,
        OP_DIVU  = 4'd12,
        OP_REMU  = 4'd13
    } op_e;

    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_BUSY = 2'd1,
        MD_DONE = 2'd2   // result held for the write-back arbiter
    } md_state_e;

endpackage

`default_nettype wire

//--- hdl/gpr_file.sv
// general register file, two async read ports, x0 hardwired to zero
`timescale 1ns/1ns
`default_nettype none

module gpr_file #(
    parameter int DATA_W = 32
) (
    input  wire                            clk,
    input  wire                            rst_n_i,
    input  wire                            we_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0] waddr_i,
    input  wire [DATA_W-1:0]               wdata_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [DATA_W-1:0]              rdata1_o,
    output logic [DATA_W-1:0]              rdata2_o
);
    import exec_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no bypass, a same-cycle write shows up next cycle
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // commits to x0 are reported upstream but must leave the storage untouched
    a_x0_kept: assert property (@(posedge clk) disable iff (!rst_n_i)
        (we_i && waddr_i == '0) |=> (regs[0] == '0));

endmodule

`default_nettype wire

//--- hdl/issue_ctrl.sv
// issue handshake, register scoreboard, operand select and dispatch register
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl #(
    parameter int DATA_W = 32
) (
    input  wire                            clk,
    input  wire                            rst_n_i,
    // issue port
    input  wire                            issue_valid_i,
    output logic                           issue_ready_o,
    input  wire exec_pkg::op_e             issue_op_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0] issue_rd_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0] issue_rs1_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0] issue_rs2_i,
    input  wire                            issue_use_imm_i,
    input  wire [DATA_W-1:0]               issue_imm_i,
    // register file read side
    output logic [exec_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [exec_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  wire [DATA_W-1:0]               rs1_data_i,
    input  wire [DATA_W-1:0]               rs2_data_i,
    input  wire                            md_busy_i,
    // commit feedback
    input  wire                            clear_valid_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0] clear_rd_i,
    // dispatch to execution units
    output logic                           alu_req_o,
    output logic                           md_req_o,
    output exec_pkg::op_e                  op_o,
    output logic [DATA_W-1:0]              opa_o,
    output logic [DATA_W-1:0]              opb_o,
    output logic [exec_pkg::REG_ADDR_W-1:0] rd_o,
    output exec_pkg::commit_id_t           id_o
);
    import exec_pkg::*;

    logic [NUM_REGS-1:0] pend_q;   // rd awaiting commit
    logic [NUM_REGS-1:0] pend_set;
    logic [NUM_REGS-1:0] pend_clr;
    commit_id_t          id_cnt_q;
    logic                is_md;
    logic                raw_waw;
    logic                md_inflight;
    logic                accept;

    assign is_md = issue_op_i inside {OP_MUL, OP_MULHU, OP_DIVU, OP_REMU};

    // bit 0 is never set, so x0 never stalls
    assign raw_waw = pend_q[issue_rs1_i] | pend_q[issue_rs2_i] | pend_q[issue_rd_i];

    // a mul/div sitting in the dispatch register counts as in flight too
    assign md_inflight   = md_busy_i | md_req_o;
    assign issue_ready_o = !raw_waw && !(is_md && md_inflight);
    assign accept        = issue_valid_i && issue_ready_o;

    assign rs1_addr_o = issue_rs1_i;
    assign rs2_addr_o = issue_rs2_i;

    assign pend_clr = clear_valid_i ? (NUM_REGS'(1) << clear_rd_i) : '0;
    assign pend_set = (accept && issue_rd_i != '0) ? (NUM_REGS'(1) << issue_rd_i) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pend_q    <= '0;
            id_cnt_q  <= '0;
            alu_req_o <= 1'b0;
            md_req_o  <= 1'b0;
        end else begin
            pend_q    <= (pend_q & ~pend_clr) | pend_set;
            alu_req_o <= accept && !is_md;
            md_req_o  <= accept && is_md;
            if (accept) begin
                id_cnt_q <= id_cnt_q + 1'b1;
            end
        end
    end

    // dispatch payload
    always_ff @(posedge clk) begin
        if (accept) begin
            op_o  <= issue_op_i;
            opa_o <= rs1_data_i;
            opb_o <= issue_use_imm_i ? issue_imm_i : rs2_data_i;
            rd_o  <= issue_rd_i;
            id_o  <= id_cnt_q;
        end
    end

    // the busy stall has to keep a second mul/div away from a running unit
    a_md_not_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(md_req_o) |-> !md_busy_i);

endmodule

`default_nettype wire

//--- hdl/muldiv_unit.sv
// iterative unsigned shift-add multiplier and restoring divider
// result held in MD_DONE until write-back accepts it
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit #(
    parameter int DATA_W = 32
) (
    input  wire                             clk,
    input  wire                             rst_n_i,
    input  wire                             req_i,
    input  wire exec_pkg::op_e              op_i,
    input  wire [DATA_W-1:0]                opa_i,
    input  wire [DATA_W-1:0]                opb_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire exec_pkg::commit_id_t       id_i,
    output logic                            busy_o,
    output logic                            res_valid_o,
    output logic [exec_pkg::REG_ADDR_W-1:0] res_rd_o,
    output logic [DATA_W-1:0]               res_data_o,
    output exec_pkg::commit_id_t            res_id_o,
    input  wire                             wb_ready_i
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(DATA_W + 1);

    md_state_e         state_q;
    logic [CNT_W-1:0]  cnt_q;
    op_e               op_q;
    logic [DATA_W-1:0] acc_hi;    // partial product high half / remainder
    logic [DATA_W-1:0] acc_lo;    // multiplier bits / quotient bits
    logic [DATA_W-1:0] opb_q;     // multiplicand or divisor
    logic              is_mul;
    logic [DATA_W:0]   mul_sum;
    logic [DATA_W:0]   div_shift;
    logic [DATA_W:0]   div_diff;
    logic              div_ge;
    logic              last_step;

    assign is_mul    = op_q inside {OP_MUL, OP_MULHU};
    assign last_step = (cnt_q == CNT_W'(DATA_W));

    assign mul_sum   = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, opb_q} : '0);
    assign div_shift = {acc_hi, acc_lo[DATA_W-1]};
    assign div_ge    = div_shift >= {1'b0, opb_q};
    assign div_diff  = div_shift - {1'b0, opb_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= MD_IDLE;
        end else begin
            case (state_q)
                MD_IDLE: if (req_i) state_q <= MD_BUSY;
                MD_BUSY: if (last_step) state_q <= MD_DONE;
                MD_DONE: if (wb_ready_i) state_q <= MD_IDLE;
                default: state_q <= MD_IDLE;
            endcase
        end
    end

    // counter restarts on every new request
    always_ff @(posedge clk) begin
        if (state_q == MD_IDLE && req_i) begin
            op_q     <= op_i;
            res_rd_o <= rd_i;
            res_id_o <= id_i;
            opb_q    <= opb_i;
            acc_hi   <= '0;
            acc_lo   <= opa_i;
            cnt_q    <= '0;
        end else if (state_q == MD_BUSY && !last_step) begin
            cnt_q <= cnt_q + 1'b1;
            if (is_mul) begin
                acc_hi <= mul_sum[DATA_W:1];
                acc_lo <= {mul_sum[0], acc_lo[DATA_W-1:1]};
            end else begin
                // divisor 0 keeps every bit set and shifts the dividend into acc_hi
                acc_hi <= div_ge ? div_diff[DATA_W-1:0] : div_shift[DATA_W-1:0];
                acc_lo <= {acc_lo[DATA_W-2:0], div_ge};
            end
        end else if (state_q == MD_BUSY) begin
            // extra cycle picks the half the opcode asks for
            case (op_q)
                OP_MULHU, OP_REMU: res_data_o <= acc_hi;
                default:           res_data_o <= acc_lo;
            endcase
        end
    end

    assign busy_o      = (state_q != MD_IDLE);
    assign res_valid_o = (state_q == MD_DONE);

    a_hold_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q == MD_DONE && !wb_ready_i) |=>
            (state_q == MD_DONE && $stable(res_data_o) && $stable(res_rd_o)
             && $stable(res_id_o)));

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
// write-back arbiter, alu first, mul/div back-pressured
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter #(
    parameter int DATA_W = 32
) (
    input  wire                             clk,
    input  wire                             rst_n_i,
    // alu result
    input  wire                             alu_valid_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0]  alu_rd_i,
    input  wire [DATA_W-1:0]                alu_data_i,
    input  wire exec_pkg::commit_id_t       alu_id_i,
    // mul/div result
    input  wire                             md_valid_i,
    input  wire [exec_pkg::REG_ADDR_W-1:0]  md_rd_i,
    input  wire [DATA_W-1:0]                md_data_i,
    input  wire exec_pkg::commit_id_t       md_id_i,
    output logic                            md_wb_ready_o,
    // register file write
    output logic                            reg_we_o,
    output logic [exec_pkg::REG_ADDR_W-1:0] reg_waddr_o,
    output logic [DATA_W-1:0]               reg_wdata_o,
    // commit report
    output logic                            commit_valid_o,
    output exec_pkg::commit_id_t            commit_id_o,
    output logic [exec_pkg::REG_ADDR_W-1:0] commit_rd_o,
    output logic [DATA_W-1:0]               commit_data_o
);

    // alu result lasts one cycle and cannot wait
    assign md_wb_ready_o = !alu_valid_i;

    always_comb begin
        commit_valid_o = alu_valid_i | md_valid_i;
        if (alu_valid_i) begin
            commit_id_o   = alu_id_i;
            commit_rd_o   = alu_rd_i;
            commit_data_o = alu_data_i;
        end else begin
            commit_id_o   = md_id_i;
            commit_rd_o   = md_rd_i;
            commit_data_o = md_data_i;
        end
    end

    assign reg_we_o    = commit_valid_o;
    assign reg_waddr_o = commit_rd_o;
    assign reg_wdata_o = commit_data_o;

    // id counter wrap must never put the same tag in both units
    a_unique_id: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(alu_valid_i && md_valid_i && alu_id_i == md_id_i));

endmodule

`default_nettype wire

//--- tests/exec_core_tb.sv
// exec_core testbench, directed table and LCG random phase
// reference register model with per-commit-id expectations
`timescale 1ns/1ns
`default_nettype none

module exec_core_tb;
    import exec_pkg::*;

    localparam int DATA_W = 32;
    localparam int SH     = $clog2(DATA_W);
    localparam int LIMIT  = 200;   // cycles allowed for any one wait
    localparam int N_RAND = 200;

    typedef struct packed {
        int                    test;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  use_imm;
        logic [DATA_W-1:0]     imm;
        logic [DATA_W-1:0]     exp;
        logic                  stall;   // ready must be low on the first cycle
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  issue_valid_i;
    logic                  issue_ready_o;
    op_e                   issue_op_i;
    logic [REG_ADDR_W-1:0] issue_rd_i, issue_rs1_i, issue_rs2_i;
    logic                  issue_use_imm_i;
    logic [DATA_W-1:0]     issue_imm_i;
    logic                  commit_valid_o;
    commit_id_t            commit_id_o;
    logic [REG_ADDR_W-1:0] commit_rd_o;
    logic [DATA_W-1:0]     commit_data_o;

    logic [DATA_W-1:0]     ref_regs [NUM_REGS];
    logic                  exp_valid [4];   // indexed by commit id
    logic [REG_ADDR_W-1:0] exp_rd [4];
    logic [DATA_W-1:0]     exp_data [4];
    logic                  exp_alu [4];
    int                    acc_cyc [4];
    commit_id_t            next_id = '0;
    int                    cyc = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    int                    err_mark = 0;
    int                    ooo_cnt = 0;     // commits that passed an older instruction
    logic [31:0]           lcg_state = 32'd70006;
    row_t                  tbl [32];
    int                    n_tbl = 0;

    exec_core #(.DATA_W(DATA_W)) dut (
        .clk(clk), .rst_n_i(rst_n_i),
        .issue_valid_i(issue_valid_i), .issue_ready_o(issue_ready_o),
        .issue_op_i(issue_op_i), .issue_rd_i(issue_rd_i),
        .issue_rs1_i(issue_rs1_i), .issue_rs2_i(issue_rs2_i),
        .issue_use_imm_i(issue_use_imm_i), .issue_imm_i(issue_imm_i),
        .commit_valid_o(commit_valid_o), .commit_id_o(commit_id_o),
        .commit_rd_o(commit_rd_o), .commit_data_o(commit_data_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];   // low bits of an LCG cycle too fast
    endfunction

    // expected result straight from the RV32I / unsigned M-extension rules
    function automatic logic [DATA_W-1:0] model(input op_e op, input logic [DATA_W-1:0] a, b);
        logic [2*DATA_W-1:0] prod;
        prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLL:   return a << b[SH-1:0];
            OP_SRL:   return a >> b[SH-1:0];
            OP_SRA:   return $signed(a) >>> b[SH-1:0];
            OP_SLT:   return DATA_W'($signed(a) < $signed(b));
            OP_SLTU:  return DATA_W'(a < b);
            OP_MUL:   return prod[DATA_W-1:0];
            OP_MULHU: return prod[2*DATA_W-1:DATA_W];
            OP_DIVU:  return (b == '0) ? '1 : a / b;
            default:  return (b == '0) ? a : a % b;   // remu
        endcase
    endfunction

    task automatic add_row(input int t, input op_e op, input logic [4:0] rd, rs1, rs2,
                           input logic use_imm, input logic [DATA_W-1:0] imm, exp,
                           input logic stall);
        tbl[n_tbl] = '{t, op, rd, rs1, rs2, use_imm, imm, exp, stall};
        n_tbl++;
    endtask

    task automatic abort_run(input string what);
        $display("timeout: no %s within %0d cycles, stopped at %0t", what, LIMIT, $time);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic issue(input op_e op, input logic [4:0] rd, rs1, rs2, input logic use_imm,
                         input logic [DATA_W-1:0] imm, exp, input logic stall);
        int n;
        n = 0;
        while (exp_valid[next_id]) begin   // tag still owned by an older instruction
            @(posedge clk);
            #1;
            n++;
            if (n > LIMIT) abort_run("free commit id");
        end
        issue_valid_i   = 1'b1;
        issue_op_i      = op;
        issue_rd_i      = rd;
        issue_rs1_i     = rs1;
        issue_rs2_i     = rs2;
        issue_use_imm_i = use_imm;
        issue_imm_i     = imm;
        @(negedge clk);
        if (stall) begin
            checks++;
            if (issue_ready_o !== 1'b0) begin
                errors++;
                $display("[ERROR] %0t issue_ready_o: got %b expected 0", $time, issue_ready_o);
            end
        end
        n = 0;
        while (issue_ready_o !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > LIMIT) abort_run("issue_ready_o");
        end
        exp_valid[next_id] = 1'b1;
        exp_rd[next_id]    = rd;
        exp_data[next_id]  = exp;
        exp_alu[next_id]   = !(op inside {OP_MUL, OP_MULHU, OP_DIVU, OP_REMU});
        acc_cyc[next_id]   = cyc;
        if (rd != '0) ref_regs[rd] = exp;
        next_id++;
        @(posedge clk);
        #1;
        issue_valid_i = 1'b0;
    endtask

    task automatic finish_test(input int t);
        int n;
        n = 0;
        while (exp_valid[0] || exp_valid[1] || exp_valid[2] || exp_valid[3]) begin
            @(posedge clk);
            #1;
            n++;
            if (n > LIMIT) abort_run("commit of every issued instruction");
        end
        if (t == 4) begin
            checks++;
            if (ooo_cnt != 2) begin
                errors++;
                $display("%0d ALU results committed ahead of the divide, 2 should have", ooo_cnt);
            end
        end
        tests++;
        $display("test %0d finished, %0d errors", t, errors - err_mark);
        err_mark = errors;
    endtask

    // every commit is matched against the expectation stored under its id
    always @(negedge clk) begin : commit_monitor
        commit_id_t id;
        id = commit_id_o;
        if (rst_n_i && commit_valid_o) begin
            checks++;
            if (!exp_valid[id]) begin
                errors++;
                $display("commit at %0t carries id %0d, which no issued instruction owns",
                         $time, id);
            end else begin
                for (int k = 0; k < 4; k++) begin
                    if (exp_valid[k] && acc_cyc[k] < acc_cyc[id]) ooo_cnt++;
                end
                if (commit_rd_o !== exp_rd[id] || commit_data_o !== exp_data[id]) begin
                    errors++;
                    $display("[ERROR] %0t commit_rd_o/commit_data_o: got %0d/%h expected %0d/%h",
                             $time, commit_rd_o, commit_data_o, exp_rd[id], exp_data[id]);
                end
                if (exp_alu[id] && cyc - acc_cyc[id] != 2) begin
                    errors++;
                    $display("[ERROR] %0t commit_valid_o latency: got %0d expected 2",
                             $time, cyc - acc_cyc[id]);
                end
                exp_valid[id] = 1'b0;
            end
        end
    end

    initial begin
        op_e               op;
        logic [15:0]       r;
        logic [DATA_W-1:0] imm;
        logic [DATA_W-1:0] opb;
        rst_n_i         = 1'b0;
        issue_valid_i   = 1'b0;
        issue_op_i      = OP_ADD;
        issue_rd_i      = '0;
        issue_rs1_i     = '0;
        issue_rs2_i     = '0;
        issue_use_imm_i = 1'b0;
        issue_imm_i     = '0;
        for (int i = 0; i < NUM_REGS; i++) ref_regs[i] = '0;
        for (int i = 0; i < 4; i++) exp_valid[i] = 1'b0;

        // test, op, rd, rs1, rs2, use_imm, imm, expected, stall
        add_row(1, OP_ADD,   5'd3,  5'd1,  5'd0, 1'b1, 32'h0,          32'h0,          1'b0);
        add_row(2, OP_ADD,   5'd1,  5'd0,  5'd0, 1'b1, 32'd100,        32'h0000_0064,  1'b0);
        add_row(2, OP_ADD,   5'd2,  5'd0,  5'd0, 1'b1, 32'hFFFF_FFF0,  32'hFFFF_FFF0,  1'b0);
        add_row(2, OP_SUB,   5'd4,  5'd1,  5'd2, 1'b0, 32'h0,          32'h0000_0074,  1'b0);
        add_row(2, OP_AND,   5'd5,  5'd2,  5'd0, 1'b1, 32'h0000_00FF,  32'h0000_00F0,  1'b0);
        add_row(2, OP_OR,    5'd6,  5'd1,  5'd5, 1'b0, 32'h0,          32'h0000_00F4,  1'b0);
        add_row(2, OP_XOR,   5'd7,  5'd2,  5'd0, 1'b1, 32'hFFFF_FFFF,  32'h0000_000F,  1'b0);
        add_row(2, OP_SLL,   5'd8,  5'd1,  5'd0, 1'b1, 32'd4,          32'h0000_0640,  1'b0);
        add_row(2, OP_SLL,   5'd13, 5'd1,  5'd0, 1'b1, 32'd33,         32'h0000_00C8,  1'b0);
        add_row(2, OP_SRL,   5'd9,  5'd2,  5'd0, 1'b1, 32'd4,          32'h0FFF_FFFF,  1'b0);
        add_row(2, OP_SRA,   5'd10, 5'd2,  5'd0, 1'b1, 32'd4,          32'hFFFF_FFFF,  1'b0);
        add_row(2, OP_SLT,   5'd11, 5'd2,  5'd1, 1'b0, 32'h0,          32'h0000_0001,  1'b0);
        add_row(2, OP_SLTU,  5'd12, 5'd2,  5'd1, 1'b0, 32'h0,          32'h0000_0000,  1'b0);
        add_row(3, OP_MUL,   5'd14, 5'd2,  5'd1, 1'b0, 32'h0,          32'hFFFF_F9C0,  1'b0);
        add_row(3, OP_MULHU, 5'd15, 5'd2,  5'd1, 1'b0, 32'h0,          32'h0000_0063,  1'b0);
        add_row(3, OP_DIVU,  5'd16, 5'd2,  5'd1, 1'b0, 32'h0,          32'h028F_5C28,  1'b0);
        add_row(3, OP_REMU,  5'd17, 5'd2,  5'd1, 1'b0, 32'h0,          32'h0000_0050,  1'b0);
        add_row(3, OP_DIVU,  5'd18, 5'd1,  5'd0, 1'b0, 32'h0,          32'hFFFF_FFFF,  1'b0);
        add_row(3, OP_REMU,  5'd19, 5'd1,  5'd0, 1'b0, 32'h0,          32'h0000_0064,  1'b0);
        add_row(4, OP_DIVU,  5'd21, 5'd1,  5'd0, 1'b1, 32'd7,          32'h0000_000E,  1'b0);
        add_row(4, OP_ADD,   5'd22, 5'd0,  5'd0, 1'b1, 32'd1,          32'h0000_0001,  1'b0);
        add_row(4, OP_ADD,   5'd23, 5'd0,  5'd0, 1'b1, 32'd2,          32'h0000_0002,  1'b0);
        add_row(4, OP_ADD,   5'd24, 5'd21, 5'd0, 1'b1, 32'h0,          32'h0000_000E,  1'b1);
        add_row(5, OP_ADD,   5'd0,  5'd1,  5'd0, 1'b1, 32'h0000_0055,  32'h0000_00B9,  1'b0);
        add_row(5, OP_ADD,   5'd26, 5'd0,  5'd0, 1'b1, 32'h0,          32'h0000_0000,  1'b0);
        // held back by x26, so this x0 read comes after the x0 write has landed
        add_row(5, OP_ADD,   5'd25, 5'd0,  5'd26, 1'b0, 32'h0,         32'h0000_0000,  1'b0);

        repeat (10) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        checks += 2;
        if (commit_valid_o !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t commit_valid_o: got %b expected 0", $time, commit_valid_o);
        end
        if (issue_ready_o !== 1'b1) begin
            errors++;
            $display("[ERROR] %0t issue_ready_o: got %b expected 1", $time, issue_ready_o);
        end
        @(posedge clk);
        #1;

        for (int i = 0; i < n_tbl; i++) begin
            if (i > 0 && tbl[i].test != tbl[i-1].test) finish_test(tbl[i-1].test);
            issue(tbl[i].op, tbl[i].rd, tbl[i].rs1, tbl[i].rs2, tbl[i].use_imm,
                  tbl[i].imm, tbl[i].exp, tbl[i].stall);
        end
        finish_test(tbl[n_tbl-1].test);

        // few registers so that hazards and stalls come up often
        for (int i = 0; i < N_RAND; i++) begin
            r   = lcg_next() % 16'd14;
            op  = op_e'(r[3:0]);
            r   = lcg_next();
            imm = {lcg_next(), lcg_next()};
            opb = r[9] ? imm : ref_regs[{2'b00, r[8:6]}];
            issue(op, {2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}, r[9], imm,
                  model(op, ref_regs[{2'b00, r[5:3]}], opb), 1'b0);
        end
        finish_test(6);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
